// ==== design/host_bridge_pkg.sv ====
`default_nettype none

package host_bridge_pkg;

  // host word layout
  localparam int MSG_WIDTH     = 32;
  localparam int OPCODE_MSB    = 31;
  localparam int OPCODE_LSB    = 28;
  localparam int PAYLOAD_WIDTH = 28;

  // opcode field, unlisted codes fall back to echo
  typedef enum logic [3:0] {
    OP_ECHO    = 4'h0,
    OP_ADD     = 4'h1,
    OP_SET_LED = 4'h2,
    OP_STATUS  = 4'h3
  } msg_opcode_e;

  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,  // waiting for an inbound word
    S_EXEC  = 2'd1,  // executor busy this cycle
    S_REPLY = 2'd2   // reply offered to the reply FIFO
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo
  import host_bridge_pkg::*;
#(
  parameter int WIDTH = MSG_WIDTH,
  parameter int DEPTH = 8
) (
  input  wire logic             BUS_CLK,
  input  wire logic             rst_n,
  input  wire logic [WIDTH-1:0] in_data,
  input  wire logic             in_valid,
  output logic                  in_ready,
  output logic      [WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  wire logic             out_ready
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CW'(DEPTH));  // low only when full
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // storage, no reset needed
  always_ff @(posedge BUS_CLK) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge BUS_CLK) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/msg_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_controller
  import host_bridge_pkg::*;
(
  input  wire logic                     BUS_CLK,
  input  wire logic                     rst_n,
  // inbound words from the inbound FIFO
  input  wire logic [MSG_WIDTH-1:0]     in_data,
  input  wire logic                     in_valid,
  output logic                          in_ready,
  // copy of each accepted word
  output logic      [MSG_WIDTH-1:0]     loop_data,
  output logic                          loop_valid,
  input  wire logic                     loop_ready,
  // executor side
  output logic                          exec_start,
  output msg_opcode_e                   exec_opcode,
  output logic      [PAYLOAD_WIDTH-1:0] exec_payload,
  input  wire logic [MSG_WIDTH-1:0]     result,
  input  wire logic                     result_needed,
  // replies toward the reply FIFO
  output logic      [MSG_WIDTH-1:0]     reply_data,
  output logic                          reply_valid,
  input  wire logic                     reply_ready
);

  ctrl_state_e          state;
  ctrl_state_e          state_next;
  logic [MSG_WIDTH-1:0] word_q;  // accepted word
  logic                 accept;

  // word taken only when the loopback can take its copy on the same edge
  assign in_ready   = (state == S_IDLE) && loop_ready;
  assign loop_valid = (state == S_IDLE) && in_valid;
  assign loop_data  = in_data;
  assign accept     = in_valid && in_ready;

  assign exec_start   = (state == S_EXEC);  // single cycle, state moves on
  assign exec_opcode  = msg_opcode_e'(word_q[OPCODE_MSB:OPCODE_LSB]);
  assign exec_payload = word_q[PAYLOAD_WIDTH-1:0];

  // executor result is settled once we are in S_REPLY
  assign reply_valid = (state == S_REPLY) && result_needed;
  assign reply_data  = result;

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (accept) begin
          state_next = S_EXEC;
        end
      end
      S_EXEC: begin
        state_next = S_REPLY;
      end
      S_REPLY: begin
        // no reply wanted: drop back at once
        if (!result_needed || reply_ready) begin
          state_next = S_IDLE;
        end
      end
      default: state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge BUS_CLK) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge BUS_CLK) begin
    if (accept) begin
      word_q <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/msg_executor.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_executor
  import host_bridge_pkg::*;
(
  input  wire logic                     BUS_CLK,
  input  wire logic                     rst_n,
  input  wire logic                     exec_start,
  input  wire msg_opcode_e              exec_opcode,
  input  wire logic [PAYLOAD_WIDTH-1:0] exec_payload,
  output logic      [MSG_WIDTH-1:0]     result,
  output logic                          result_needed,
  output logic      [7:0]               led
);

  logic [MSG_WIDTH-1:0] acc_q;    // running sum for OP_ADD
  logic [MSG_WIDTH-1:0] count_q;  // words consumed so far
  logic [MSG_WIDTH-1:0] acc_sum;

  assign acc_sum = acc_q + {{(MSG_WIDTH - PAYLOAD_WIDTH){1'b0}}, exec_payload};  // wraps

  // control state and architectural registers
  always_ff @(posedge BUS_CLK) begin
    if (!rst_n) begin
      acc_q         <= '0;
      count_q       <= '0;
      led           <= '0;
      result_needed <= 1'b0;
    end else if (exec_start) begin
      count_q <= count_q + 1'b1;
      case (exec_opcode)
        OP_ADD: begin
          acc_q         <= acc_sum;
          result_needed <= 1'b1;
        end
        OP_SET_LED: begin
          led           <= exec_payload[7:0];
          result_needed <= 1'b0;  // silent
        end
        default: result_needed <= 1'b1;  // echo, status, unknown
      endcase
    end
  end

  // reply word
  always_ff @(posedge BUS_CLK) begin
    if (exec_start) begin
      case (exec_opcode)
        OP_ADD:     result <= acc_sum;
        OP_STATUS:  result <= count_q;  // count before this word
        OP_SET_LED: result <= result;
        default:    result <= {exec_opcode, exec_payload};  // echo rebuilt
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/host_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bridge_top
  import host_bridge_pkg::*;
#(
  parameter int FIFO_DEPTH = 8,
  parameter int LOOP_DEPTH = 4
) (
  input  wire logic                 BUS_CLK,
  input  wire logic                 rst_n,
  input  wire logic [MSG_WIDTH-1:0] wr_data,
  input  wire logic                 wr_valid,
  output logic                      wr_ready,
  output logic      [MSG_WIDTH-1:0] rd_data,
  output logic                      rd_valid,
  input  wire logic                 rd_ready,
  output logic      [MSG_WIDTH-1:0] loop_data,
  output logic                      loop_valid,
  input  wire logic                 loop_ready,
  output logic      [7:0]           led
);

  logic [MSG_WIDTH-1:0]     in_data;     // inbound FIFO -> controller
  logic                     in_valid;
  logic                     in_ready;
  logic [MSG_WIDTH-1:0]     lb_data;     // controller -> loopback FIFO
  logic                     lb_valid;
  logic                     lb_ready;
  logic [MSG_WIDTH-1:0]     reply_data;  // controller -> reply FIFO
  logic                     reply_valid;
  logic                     reply_ready;
  logic                     exec_start;
  msg_opcode_e              exec_opcode;
  logic [PAYLOAD_WIDTH-1:0] exec_payload;
  logic [MSG_WIDTH-1:0]     result;
  logic                     result_needed;

  stream_fifo #(.WIDTH(MSG_WIDTH), .DEPTH(FIFO_DEPTH)) inbound_fifo (
    .BUS_CLK, .rst_n,
    .in_data(wr_data), .in_valid(wr_valid), .in_ready(wr_ready),
    .out_data(in_data), .out_valid(in_valid), .out_ready(in_ready)
  );

  stream_fifo #(.WIDTH(MSG_WIDTH), .DEPTH(FIFO_DEPTH)) reply_fifo (
    .BUS_CLK, .rst_n,
    .in_data(reply_data), .in_valid(reply_valid), .in_ready(reply_ready),
    .out_data(rd_data), .out_valid(rd_valid), .out_ready(rd_ready)
  );

  stream_fifo #(.WIDTH(MSG_WIDTH), .DEPTH(LOOP_DEPTH)) loop_fifo (
    .BUS_CLK, .rst_n,
    .in_data(lb_data), .in_valid(lb_valid), .in_ready(lb_ready),
    .out_data(loop_data), .out_valid(loop_valid), .out_ready(loop_ready)
  );

  msg_controller msg_controller_i (
    .BUS_CLK, .rst_n,
    .in_data, .in_valid, .in_ready,
    .loop_data(lb_data), .loop_valid(lb_valid), .loop_ready(lb_ready),
    .exec_start, .exec_opcode, .exec_payload,
    .result, .result_needed,
    .reply_data, .reply_valid, .reply_ready
  );

  msg_executor msg_executor_i (
    .BUS_CLK, .rst_n,
    .exec_start, .exec_opcode, .exec_payload,
    .result, .result_needed, .led
  );

endmodule

`default_nettype wire

// ==== bench/host_bridge_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bridge_assert
  import host_bridge_pkg::*;
(
  input wire logic                 BUS_CLK,
  input wire logic                 rst_n,
  input wire ctrl_state_e          state,
  input wire logic                 exec_start,
  input wire logic                 loop_valid,
  input wire logic [MSG_WIDTH-1:0] reply_data,
  input wire logic                 reply_valid,
  input wire logic                 reply_ready
);

  logic was_in_reset = 1'b0;  // high from the second reset cycle on
  int   fail_count   = 0;     // assertion failures so far

  always @(posedge BUS_CLK) begin
    was_in_reset <= !rst_n;
  end

  // stalled reply keeps valid and word
  reply_hold: assert property (@(posedge BUS_CLK) disable iff (!rst_n)
    reply_valid && !reply_ready |=> reply_valid && $stable(reply_data))
    else begin
      $error("reply_valid dropped or reply_data changed while stalled");
      fail_count++;
    end

  exec_pulse: assert property (@(posedge BUS_CLK) disable iff (!rst_n)
    exec_start |=> !exec_start)
    else begin
      $error("exec_start held for more than one cycle");
      fail_count++;
    end

  // once the first reset edge has passed, everything stays quiet
  reset_quiet: assert property (@(posedge BUS_CLK)
    was_in_reset && !rst_n |-> !reply_valid && !loop_valid && !exec_start && state == S_IDLE)
    else begin
      $error("controller output active during reset");
      fail_count++;
    end

endmodule

bind msg_controller host_bridge_assert host_bridge_assert_i (
  .BUS_CLK, .rst_n, .state, .exec_start, .loop_valid,
  .reply_data, .reply_valid, .reply_ready
);

`default_nettype wire

// ==== bench/tb_host_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_host_bridge
  import host_bridge_pkg::*;
();

  localparam int NUM_WORDS      = 400;
  localparam int TIMEOUT_CYCLES = NUM_WORDS * 10 + 1000;

  logic                 BUS_CLK = 1'b0;
  logic                 rst_n;
  logic [MSG_WIDTH-1:0] wr_data;
  logic                 wr_valid;
  logic                 wr_ready;
  logic [MSG_WIDTH-1:0] rd_data;
  logic                 rd_valid;
  logic                 rd_ready;
  logic [MSG_WIDTH-1:0] loop_data;
  logic                 loop_valid;
  logic                 loop_ready;
  logic [7:0]           led;

  logic [31:0]          rng_state = 32'h1694d7f3;
  logic [MSG_WIDTH-1:0] loop_q[$];   // expected loopback words
  logic [MSG_WIDTH-1:0] reply_q[$];  // expected replies
  logic [MSG_WIDTH-1:0] model_acc;
  logic [7:0]           model_led;
  bit timed_out      = 1'b0;
  int words_issued   = 0;
  int words_accepted = 0;
  int loop_seen      = 0;
  int reply_seen     = 0;
  int cycle_count    = 0;
  int stall_cycles   = 0;  // cycles with wr_ready low
  int rd_hold        = 0;
  int loop_hold      = 0;
  int loop_errors    = 0;
  int reply_errors   = 0;
  int other_errors   = 0;
  int assert_errors  = 0;

  always #50 BUS_CLK = ~BUS_CLK;

  host_bridge_top #(
    .FIFO_DEPTH(8),
    .LOOP_DEPTH(4)
  ) host_bridge_top_i (
    .BUS_CLK, .rst_n,
    .wr_data, .wr_valid, .wr_ready,
    .rd_data, .rd_valid, .rd_ready,
    .loop_data, .loop_valid, .loop_ready,
    .led
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [MSG_WIDTH-1:0] make_word();
    logic [31:0] r_op;
    logic [31:0] r_pay;
    logic [3:0]  op;
    r_op  = next_random();
    r_pay = next_random();
    op = r_op[31] ? {2'b00, r_op[30:29]} : r_op[30:27];  // biased toward defined codes
    return {op, r_pay[31:4]};
  endfunction

  // ready held at one level for a random stretch
  task automatic update_ready(inout logic ready, inout int hold);
    logic [31:0] r;
    if (hold > 0) begin
      hold--;
    end else begin
      r = next_random();
      ready = (r[31:30] != 2'b00);
      hold  = ready ? int'(r[29:25]) : int'(r[29:26]);
    end
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    r = next_random();
    if (wr_valid && words_accepted == words_issued) begin
      wr_valid = 1'b0;  // taken at the last edge
    end
    if (!wr_valid && words_issued < NUM_WORDS && r[31:30] != 2'b00) begin
      wr_data  = make_word();
      wr_valid = 1'b1;
      words_issued++;
    end
    update_ready(rd_ready, rd_hold);
    update_ready(loop_ready, loop_hold);
  endtask

  // words execute in arrival order, so the model runs at inbound acceptance
  task automatic model_accept(input logic [MSG_WIDTH-1:0] word);
    logic [3:0]               op;
    logic [PAYLOAD_WIDTH-1:0] payload;
    op      = word[OPCODE_MSB:OPCODE_LSB];
    payload = word[PAYLOAD_WIDTH-1:0];
    loop_q.push_back(word);
    case (op)
      OP_ADD: begin
        model_acc = model_acc + MSG_WIDTH'(payload);  // 32-bit wrap
        reply_q.push_back(model_acc);
      end
      OP_SET_LED: model_led = payload[7:0];  // no reply
      OP_STATUS:  reply_q.push_back(MSG_WIDTH'(words_accepted));
      default:    reply_q.push_back(word);
    endcase
    words_accepted++;
  endtask

  task automatic check_reply(input logic [MSG_WIDTH-1:0] got);
    logic [MSG_WIDTH-1:0] exp;
    reply_seen++;
    assert (reply_q.size() > 0) else begin
      reply_errors++;
      $display("reply word %h arrived with no reply outstanding", got);
    end
    if (reply_q.size() > 0) begin
      exp = reply_q.pop_front();
      assert (got === exp) else begin
        reply_errors++;
        $display("CHECK FAILED rd_data: got %h expected %h", got, exp);
      end
    end
  endtask

  task automatic check_loop(input logic [MSG_WIDTH-1:0] got);
    logic [MSG_WIDTH-1:0] exp;
    loop_seen++;
    assert (loop_q.size() > 0) else begin
      loop_errors++;
      $display("loopback word %h arrived with no word outstanding", got);
    end
    if (loop_q.size() > 0) begin
      exp = loop_q.pop_front();
      assert (got === exp) else begin
        loop_errors++;
        $display("CHECK FAILED loop_data: got %h expected %h", got, exp);
      end
    end
  endtask

  function automatic bit run_complete();
    return words_accepted == NUM_WORDS && loop_seen == NUM_WORDS && reply_q.size() == 0;
  endfunction

  // transfers seen on the rising edge, inputs only move on the falling one
  always @(posedge BUS_CLK) begin
    if (rst_n) begin
      cycle_count++;
      if (!wr_ready) begin
        stall_cycles++;
      end
      if (wr_valid && wr_ready) begin
        model_accept(wr_data);
      end
      if (rd_valid && rd_ready) begin
        check_reply(rd_data);
      end
      if (loop_valid && loop_ready) begin
        check_loop(loop_data);
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    wr_data    = '0;
    wr_valid   = 1'b0;
    rd_ready   = 1'b0;
    loop_ready = 1'b0;
    model_acc  = '0;
    model_led  = '0;
    repeat (10) @(negedge BUS_CLK);
    rst_n = 1'b1;
    @(negedge BUS_CLK);
    assert (rd_valid === 1'b0) else begin
      other_errors++;
      $display("CHECK FAILED rd_valid: got %h expected %h", rd_valid, 1'b0);
    end
    assert (loop_valid === 1'b0) else begin
      other_errors++;
      $display("CHECK FAILED loop_valid: got %h expected %h", loop_valid, 1'b0);
    end
    assert (led === 8'h00) else begin
      other_errors++;
      $display("CHECK FAILED led: got %h expected %h", led, 8'h00);
    end

    while (!run_complete() && cycle_count < TIMEOUT_CYCLES) begin
      drive_cycle();
      @(negedge BUS_CLK);
    end
    timed_out  = !run_complete();
    wr_valid   = 1'b0;
    rd_ready   = 1'b1;
    loop_ready = 1'b1;
    repeat (2) @(negedge BUS_CLK);  // last SET_LED has executed

    if (timed_out) begin
      other_errors++;
      $display("run timed out after %0d cycles with words outstanding:", cycle_count);
      $display("  %0d not accepted, %0d loopback and %0d replies missing",
               NUM_WORDS - words_accepted, NUM_WORDS - loop_seen, reply_q.size());
    end else begin
      assert (led === model_led) else begin
        other_errors++;
        $display("CHECK FAILED led: got %h expected %h", led, model_led);
      end
      assert (stall_cycles > 0) else begin
        other_errors++;
        $display("wr_ready never fell, so inbound back-pressure was not seen");
      end
    end

    assert_errors = host_bridge_top_i.msg_controller_i.host_bridge_assert_i.fail_count;
    $display("errors: loopback %0d, reply %0d, assertion %0d, other %0d (replies seen %0d)",
             loop_errors, reply_errors, assert_errors, other_errors, reply_seen);
    if (loop_errors + reply_errors + assert_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
design/host_bridge_pkg.sv
design/stream_fifo.sv
design/msg_controller.sv
design/msg_executor.sv
design/host_bridge_top.sv
bench/host_bridge_assert.sv
bench/tb_host_bridge.sv

// ==== Bender.yml ====
package:
  name: host_bridge

sources:
  - files:
      - design/host_bridge_pkg.sv
      - design/stream_fifo.sv
      - design/msg_controller.sv
      - design/msg_executor.sv
      - design/host_bridge_top.sv
  - target: test
    files:
      - bench/host_bridge_assert.sv
      - bench/tb_host_bridge.sv
